// ==== adder_tree_25.f ====
rtl/adder_tree_pkg.sv
rtl/lane_adder.sv
rtl/tree_layer.sv
rtl/stage_valid_timer.sv
rtl/adder_tree_25.sv
sim/tb_adder_tree_25.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the adder tree testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_adder_tree_25 \
    -f adder_tree_25.f \
    -o sim_adder_tree_25

./obj_dir/sim_adder_tree_25 > sim.log
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/tb_adder_tree_25.sv ====
// ****************************************
// adder tree testbench
// random and directed vectors into the
// 25-input tree, sums and timing checked
// ****************************************

`timescale 1ns/1ps

module tb_adder_tree_25
    import adder_tree_pkg::*;
();

    localparam int SEED = 56688;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_TIMEOUT = 100;

    logic      clk = 1'b0;
    logic      rst;
    logic      data_v;
    elem_vec_t elems;
    elem_t     sum;
    logic      sum_valid;

    // expected sums and the cycle each one is due in
    elem_t exp_sum_q [$];
    int    exp_time_q [$];
    int    edge_count = 0;
    string test_name;

    int value_errors = 0;
    int timing_errors = 0;
    int unexpected_errors = 0;
    int timeout_errors = 0;
    int unsigned seed_ret;
    int unsigned gap;
    elem_vec_t vec;

    adder_tree_25 DUT (
        .clk       (clk),
        .rst       (rst),
        .data_v    (data_v),
        .elems     (elems),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    // 10 ns period
    always #5 clk = ~clk;

    // ****************************************
    // reference model
    // ****************************************

    // plain sum in a wide accumulator, then keep the low 16 bits
    function automatic elem_t ref_sum(input elem_vec_t v);
        int unsigned total;
        total = 0;
        for (int i = 0; i < N_ELEMS; i++) begin
            total = total + 32'(v[i]);
        end
        return elem_t'(total);
    endfunction

    function automatic elem_vec_t random_vector();
        elem_vec_t v;
        for (int i = 0; i < N_ELEMS; i++) begin
            v[i] = elem_t'($urandom());
        end
        return v;
    endfunction

    // ****************************************
    // scoreboard
    // ****************************************

    // inputs are stable at the rising edge, driven on the falling one
    // edge_count still numbers the cycle that just ends, the one data_v was driven in
    always @(posedge clk) begin
        if (!rst) begin
            // reset drops everything in flight
            exp_sum_q.delete();
            exp_time_q.delete();
        end else if (data_v) begin
            exp_sum_q.push_back(ref_sum(elems));
            exp_time_q.push_back(edge_count + TREE_LATENCY);
        end
        edge_count = edge_count + 1;
    end

    task automatic check_sum(input string name, input elem_t exp, input elem_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: sum expected 0x%04h, actual 0x%04h", name, exp, act);
        end
    endtask

    task automatic check_valid_time(input string name, input int exp, input int act);
        if (exp != act) begin
            timing_errors++;
            $display("[ERROR] %s: sum_valid cycle expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // outputs only move on the rising edge, so look at them halfway
    always @(negedge clk) begin
        if (sum_valid) begin
            if (exp_sum_q.size() == 0) begin
                unexpected_errors++;
                $display("%s: sum_valid pulsed at edge %0d with no vector in flight",
                         test_name, edge_count);
            end else begin
                check_sum(test_name, exp_sum_q.pop_front(), sum);
                check_valid_time(test_name, exp_time_q.pop_front(), edge_count);
            end
        end
    end

    // ****************************************
    // stimulus
    // ****************************************

    // one vector for one cycle, starting on a falling edge
    task automatic send_vector(input elem_vec_t v);
        data_v = 1'b1;
        elems = v;
        @(negedge clk);
    endtask

    // junk on elems while idle, it must not be loaded
    task automatic idle(input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            data_v = 1'b0;
            elems = random_vector();
            @(negedge clk);
        end
    endtask

    // bounded wait until every expected sum came out
    task automatic drain(input int limit);
        int waited;
        waited = 0;
        // no new vector enters while the pipe empties
        data_v = 1'b0;
        while (exp_sum_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_sum_q.size() != 0) begin
            timeout_errors++;
            $display("%s: timed out with %0d results still missing after %0d cycles",
                     test_name, exp_sum_q.size(), limit);
            exp_sum_q.delete();
            exp_time_q.delete();
        end
        // a few quiet cycles catch stray pulses
        idle(3);
    endtask

    // ****************************************
    // test sequence
    // ****************************************

    initial begin
        seed_ret = $urandom(SEED);
        rst = 1'b0;
        data_v = 1'b0;
        elems = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        idle(2);

        // full throughput, one vector every cycle
        test_name = "back_to_back";
        for (int n = 0; n < 40; n++) begin
            send_vector(random_vector());
        end
        drain(DRAIN_TIMEOUT);

        test_name = "random_gaps";
        for (int n = 0; n < 40; n++) begin
            send_vector(random_vector());
            gap = $urandom_range(3, 0);
            idle(gap);
        end
        drain(DRAIN_TIMEOUT);

        // every lane wraps, no carry may leak into the next lane
        test_name = "all_ones";
        for (int i = 0; i < N_ELEMS; i++) begin
            vec[i] = 16'hffff;
        end
        check_sum("all_ones_ref", 16'hffe7, ref_sum(vec));
        send_vector(vec);
        send_vector(vec);
        drain(DRAIN_TIMEOUT);

        // walks every lane position, index 24 takes the delay line
        test_name = "one_hot";
        for (int idx = 0; idx < N_ELEMS; idx++) begin
            vec = '0;
            vec[idx] = 16'h1234;
            check_sum("one_hot_ref", 16'h1234, ref_sum(vec));
            send_vector(vec);
        end
        drain(DRAIN_TIMEOUT);

        // reset cuts items out of the pipe
        test_name = "reset_in_flight";
        for (int n = 0; n < 6; n++) begin
            send_vector(random_vector());
        end
        idle(2);
        rst = 1'b0;
        // data_v during reset is ignored
        send_vector(random_vector());
        idle(2);
        rst = 1'b1;
        idle(15);
        for (int n = 0; n < 8; n++) begin
            send_vector(random_vector());
            gap = $urandom_range(2, 0);
            idle(gap);
        end
        drain(DRAIN_TIMEOUT);

        $display("errors: value %0d, timing %0d, unexpected %0d, timeout %0d",
                 value_errors, timing_errors, unexpected_errors, timeout_errors);
        if (value_errors + timing_errors + unexpected_errors + timeout_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/adder_tree_25.sv ====
// ****************************************
// 25-input adder tree
// pipelined sum of 25 unsigned elements,
// modulo 2^16, result 11 cycles after entry
// ****************************************

`timescale 1ns/1ps

module adder_tree_25
    import adder_tree_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      data_v,
    input  elem_vec_t elems,
    output elem_t     sum,
    output logic      sum_valid
);

    // ****************************************
    // control
    // ****************************************

    stage_valid_t stage_valid;

    // one valid shift register times every stage
    stage_valid_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .data_v      (data_v),
        .stage_valid (stage_valid),
        .sum_valid   (sum_valid)
    );

    // ****************************************
    // input capture
    // ****************************************

    elem_vec_t elems_q;

    // bit 0 of stage_valid is data_v itself
    always_ff @(posedge clk) begin
        if (stage_valid[0]) begin
            elems_q <= elems;
        end
    end

    // ****************************************
    // element packing
    // ****************************************

    // word i carries element 2i+1 high, 2i low
    lane_pair_t words [N_WORDS];

    always_comb begin
        for (int i = 0; i < N_WORDS; i++) begin
            words[i].word = {elems_q[2*i+1], elems_q[2*i]};
        end
    end

    // ****************************************
    // odd element delay line
    // ****************************************

    // element 24 has no partner, it rides along here
    // until layer 2 has a free lane for it
    elem_t odd_q [ODD_DELAY];

    // shifts every cycle, items keep their spacing
    always_ff @(posedge clk) begin
        odd_q[0] <= elems_q[N_ELEMS-1];
        for (int i = 1; i < ODD_DELAY; i++) begin
            odd_q[i] <= odd_q[i-1];
        end
    end

    // ****************************************
    // layer 0, 12 words to 6
    // ****************************************

    lane_pair_t l0_a [L0_PAIRS];
    lane_pair_t l0_b [L0_PAIRS];
    lane_pair_t l0_s [L0_PAIRS];

    // word i meets word i+6
    always_comb begin
        for (int i = 0; i < L0_PAIRS; i++) begin
            l0_a[i] = words[i];
            l0_b[i] = words[i+L0_PAIRS];
        end
    end

    tree_layer #(.N_PAIRS(L0_PAIRS)) u_layer0 (
        .clk  (clk),
        .load (stage_valid[1 +: LANE_LATENCY]),
        .a    (l0_a),
        .b    (l0_b),
        .s    (l0_s)
    );

    // ****************************************
    // layer 1, 6 words to 3
    // ****************************************

    lane_pair_t l1_a [L1_PAIRS];
    lane_pair_t l1_b [L1_PAIRS];
    lane_pair_t l1_s [L1_PAIRS];

    always_comb begin
        for (int i = 0; i < L1_PAIRS; i++) begin
            l1_a[i] = l0_s[i];
            l1_b[i] = l0_s[i+L1_PAIRS];
        end
    end

    tree_layer #(.N_PAIRS(L1_PAIRS)) u_layer1 (
        .clk  (clk),
        .load (stage_valid[1 + LANE_LATENCY +: LANE_LATENCY]),
        .a    (l1_a),
        .b    (l1_b),
        .s    (l1_s)
    );

    // ****************************************
    // layer 2, 3 words plus element 24 to 2
    // ****************************************

    lane_pair_t l2_a [L2_PAIRS];
    lane_pair_t l2_b [L2_PAIRS];
    lane_pair_t l2_s [L2_PAIRS];

    always_comb begin
        l2_a[0] = l1_s[0];
        l2_b[0] = l1_s[1];
        l2_a[1] = l1_s[2];
        // delayed element 24 joins in the low lane
        l2_b[1].lane.hi = '0;
        l2_b[1].lane.lo = odd_q[ODD_DELAY-1];
    end

    tree_layer #(.N_PAIRS(L2_PAIRS)) u_layer2 (
        .clk  (clk),
        .load (stage_valid[1 + 2*LANE_LATENCY +: LANE_LATENCY]),
        .a    (l2_a),
        .b    (l2_b),
        .s    (l2_s)
    );

    // ****************************************
    // layer 3, 2 words to 1
    // ****************************************

    lane_pair_t l3_a [L3_PAIRS];
    lane_pair_t l3_b [L3_PAIRS];
    lane_pair_t l3_s [L3_PAIRS];

    always_comb begin
        l3_a[0] = l2_s[0];
        l3_b[0] = l2_s[1];
    end

    tree_layer #(.N_PAIRS(L3_PAIRS)) u_layer3 (
        .clk  (clk),
        .load (stage_valid[1 + 3*LANE_LATENCY +: LANE_LATENCY]),
        .a    (l3_a),
        .b    (l3_b),
        .s    (l3_s)
    );

    // ****************************************
    // fold, two lanes into one sum
    // ****************************************

    lane_pair_t fold_a;
    lane_pair_t fold_b;
    lane_pair_t fold_s;

    // both halves go through low lanes,
    // the high lane just adds zeros
    always_comb begin
        fold_a.lane.hi = '0;
        fold_a.lane.lo = l3_s[0].lane.hi;
        fold_b.lane.hi = '0;
        fold_b.lane.lo = l3_s[0].lane.lo;
    end

    lane_adder u_fold (
        .clk  (clk),
        .load (stage_valid[1 + 4*LANE_LATENCY +: LANE_LATENCY]),
        .a    (fold_a),
        .b    (fold_b),
        .s    (fold_s)
    );

    // fold output register holds the result
    // in the sum_valid cycle
    assign sum = fold_s.lane.lo;

    // ****************************************
    // checks
    // ****************************************

    // a valid result must come from fully loaded
    // registers all the way down the tree
    a_sum_known: assert property (
        @(posedge clk) sum_valid |-> !$isunknown(sum)
    ) else $error("adder_tree_25: unknown bits in sum while sum_valid");

endmodule

// ==== rtl/stage_valid_timer.sv ====
// ****************************************
// stage valid timer
// valid shift register timing every
// pipeline stage and the output pulse
// ****************************************

`timescale 1ns/1ps

module stage_valid_timer
    import adder_tree_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         data_v,
    // bit 0 is the input load strobe,
    // bit k marks an item in pipeline register k
    output stage_valid_t stage_valid,
    output logic         sum_valid
);

    // ****************************************
    // occupancy shift register
    // ****************************************

    // occ[k] is high when an item sits in register k+1
    logic [TREE_LATENCY-1:0] occ;

    always_ff @(posedge clk) begin
        if (!rst) begin
            occ <= '0;
        end else begin
            // every item advances one stage per cycle
            occ <= {occ[TREE_LATENCY-2:0], data_v};
        end
    end

    // ****************************************
    // outputs
    // ****************************************

    // the input register loads straight on data_v
    assign stage_valid = {occ[TREE_LATENCY-2:0], data_v};

    // item has reached the fold output register
    assign sum_valid = occ[TREE_LATENCY-1];

    // ****************************************
    // checks
    // ****************************************

    // end to end latency of the whole tree,
    // as long as no reset cut the item out
    a_latency: assert property (
        @(posedge clk) rst [*TREE_LATENCY] |=>
            (sum_valid == $past(data_v, TREE_LATENCY))
    ) else $error("stage_valid_timer: sum_valid off the data_v timing");

    // reset flushes every item in flight
    a_reset_flush: assert property (
        @(posedge clk) !rst |=> (occ == '0)
    ) else $error("stage_valid_timer: valid bit set right after reset");

endmodule

// ==== rtl/tree_layer.sv ====
// ****************************************
// tree layer
// one layer of the adder tree as an array
// of lane adders sharing one load pair
// ****************************************

`timescale 1ns/1ps

module tree_layer
    import adder_tree_pkg::*;
#(
    // number of lane adders in this layer
    parameter int N_PAIRS = 1
) (
    input  logic                    clk,
    // load enables of the two adder stages
    input  logic [LANE_LATENCY-1:0] load,
    // a[i] is added to b[i]
    input  lane_pair_t              a [N_PAIRS],
    input  lane_pair_t              b [N_PAIRS],
    output lane_pair_t              s [N_PAIRS]
);

    // ****************************************
    // adder array
    // ****************************************

    // all adders of a layer move in lock step,
    // so one load pair serves the whole array
    genvar i;
    generate
        for (i = 0; i < N_PAIRS; i++) begin : g_pair
            lane_adder u_add (
                .clk  (clk),
                .load (load),
                .a    (a[i]),
                .b    (b[i]),
                .s    (s[i])
            );
        end
    endgenerate

endmodule

// ==== rtl/lane_adder.sv ====
// ****************************************
// lane adder
// two-stage pipelined adder with two
// independent 16-bit lanes in one word
// ****************************************

`timescale 1ns/1ps

module lane_adder
    import adder_tree_pkg::*;
(
    input  logic                    clk,
    // load[0] for stage 1, load[1] for stage 2
    input  logic [LANE_LATENCY-1:0] load,
    input  lane_pair_t              a,
    input  lane_pair_t              b,
    output lane_pair_t              s
);

    // ****************************************
    // stage 1, per-lane sums
    // ****************************************

    // each lane wraps at ELEM_W bits, no carry crosses over
    elem_t lo_sum;
    elem_t hi_sum;

    always_ff @(posedge clk) begin
        if (load[0]) begin
            lo_sum <= a.lane.lo + b.lane.lo;
            hi_sum <= a.lane.hi + b.lane.hi;
        end
    end

    // ****************************************
    // stage 2, output register
    // ****************************************

    // holds its value while load[1] is low
    always_ff @(posedge clk) begin
        if (load[1]) begin
            s.lane.lo <= lo_sum;
            s.lane.hi <= hi_sum;
        end
    end

    // ****************************************
    // checks
    // ****************************************

    // stage 2 only ever takes what stage 1 loaded
    // one cycle before
    a_stage_order: assert property (
        @(posedge clk) load[1] |-> $past(load[0])
    ) else $error("lane_adder: stage 2 load without a stage 1 load");

endmodule

// ==== rtl/adder_tree_pkg.sv ====
// ****************************************
// adder tree package
// widths, layer sizes, latencies and the
// element and lane types of the 25-input tree
// ****************************************

package adder_tree_pkg;

    // ****************************************
    // sizes
    // ****************************************

    // one element and one packed word of two elements
    localparam int ELEM_W = 16;
    localparam int N_ELEMS = 25;

    // element 24 has no partner and is left over
    localparam int N_WORDS = N_ELEMS / 2;

    // adders in each layer of the tree
    localparam int L0_PAIRS = N_WORDS / 2;
    localparam int L1_PAIRS = L0_PAIRS / 2;
    localparam int L2_PAIRS = 2;
    localparam int L3_PAIRS = 1;

    // ****************************************
    // latencies
    // ****************************************

    // register stages inside one lane adder
    localparam int LANE_LATENCY = 2;

    // four tree layers plus the final fold
    localparam int N_LAYERS = 5;

    // input register to layer 2 first stage
    localparam int ODD_DELAY = 1 + 2 * LANE_LATENCY - 1;

    // one cycle of input capture, then every layer
    localparam int TREE_LATENCY = 1 + N_LAYERS * LANE_LATENCY;

    // ****************************************
    // types
    // ****************************************

    typedef logic [ELEM_W-1:0] elem_t;

    // element 0 sits in the low bits
    typedef elem_t [N_ELEMS-1:0] elem_vec_t;

    // packing fills the raw word, adders work on the two lanes
    typedef union packed {
        struct packed {
            elem_t hi;
            elem_t lo;
        } lane;
        logic [2*ELEM_W-1:0] word;
    } lane_pair_t;

    typedef logic [TREE_LATENCY-1:0] stage_valid_t;

endpackage
